// File: src/fft_tail_cfg.svh
`ifndef FFT_TAIL_CFG_SVH
`define FFT_TAIL_CFG_SVH

//////////////////////////////////////////////////
// Sample formats
//////////////////////////////////////////////////

// Q6.15 input parts
`define FFT_NB_IN   21

// Q7.15 after the butterfly, one guard bit for sum and difference
`define FFT_NB_WIDE 22

// Q6.4 output parts
`define FFT_NB_OUT  10

// Fraction bits removed by the output floor
`define FFT_SHIFT   11

//////////////////////////////////////////////////
// Stage timing
//////////////////////////////////////////////////

// Delay line depth and switch half-period
`define FFT_DELAY   16

// Cycles until the earlier stages have filled
`define FFT_FILL    47

`endif

// File: src/fft_tail_pkg.sv
`include "fft_tail_cfg.svh"

package fft_tail_pkg;

   // One complex sample at each point of the datapath
   typedef struct packed {
      logic [`FFT_NB_IN-1:0] re;
      logic [`FFT_NB_IN-1:0] im;
   } cplx_in_t;

   typedef struct packed {
      logic [`FFT_NB_WIDE-1:0] re;
      logic [`FFT_NB_WIDE-1:0] im;
   } cplx_wide_t;

   typedef struct packed {
      logic [`FFT_NB_OUT-1:0] re;
      logic [`FFT_NB_OUT-1:0] im;
   } cplx_out_t;

   // A lane carries the up and down samples of one butterfly
   typedef struct packed {
      cplx_in_t up;
      cplx_in_t down;
   } lane_in_t;

   typedef struct packed {
      cplx_wide_t up;
      cplx_wide_t down;
   } lane_wide_t;

   typedef struct packed {
      cplx_out_t up;
      cplx_out_t down;
   } lane_out_t;

   // Sequencer waits for the pipeline to fill, then runs
   typedef enum logic {
      SEQ_FILL = 1'b0,
      SEQ_RUN  = 1'b1
   } seq_state_t;

endpackage

// File: src/stage_sequencer.sv
`timescale 1ns/1ps

`include "fft_tail_cfg.svh"

module stage_sequencer
   import fft_tail_pkg::*;
#(
   parameter int DELAY = `FFT_DELAY,
   parameter int FILL  = `FFT_FILL
) (
   input  logic clk,
   input  logic rst_n,
   output logic switch,
   output logic out_valid
);

   localparam int FILL_W = $clog2(FILL + 1);
   // Phase bit SW_BIT is the switch, the bit above it saturates
   localparam int SW_BIT = $clog2(DELAY);
   localparam int PH_W   = SW_BIT + 2;
   localparam logic [PH_W-1:0] PH_VALID = PH_W'(2 * DELAY);

   seq_state_t        state;
   logic [FILL_W-1:0] fill_cnt;
   logic [PH_W-1:0]   phase;
   logic [PH_W-1:0]   phase_inc;

   assign phase_inc = phase + 1'b1;

   //////////////////////////////////////////////////
   // Fill count and run phase
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state     <= SEQ_FILL;
         fill_cnt  <= '0;
         phase     <= '0;
         out_valid <= 1'b0;
      end else begin
         case (state)
            SEQ_FILL: begin
               fill_cnt <= fill_cnt + 1'b1;
               if (fill_cnt == FILL_W'(FILL - 1)) begin
                  state <= SEQ_RUN;
               end
            end
            SEQ_RUN: begin
               // Top bit sticks once set, low bits keep wrapping
               phase <= {phase[PH_W-1] | phase_inc[PH_W-1], phase_inc[PH_W-2:0]};
               // Both delay lines now hold frame-aligned data
               if (phase == PH_VALID) begin
                  out_valid <= 1'b1;
               end
            end
            default: begin
               state <= SEQ_FILL;
            end
         endcase
      end
   end

   // High on odd half-periods of the phase count
   assign switch = phase[SW_BIT];

endmodule

// File: src/mdc_butterfly.sv
`timescale 1ns/1ps

`include "fft_tail_cfg.svh"

module mdc_butterfly
   import fft_tail_pkg::*;
#(
   parameter int DELAY = `FFT_DELAY
) (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       switch,
   input  lane_in_t   lane_in,
   output lane_wide_t lane_out
);

   // Input side delay on the down sample
   cplx_in_t down_dly [DELAY];
   // Output side delay on the upper branch
   cplx_in_t up_dly [DELAY];

   cplx_in_t dd;
   cplx_in_t upper;
   cplx_in_t b;
   cplx_in_t a;

   // Sign-extended sum or difference of two complex samples
   function automatic cplx_wide_t bf_combine(
      input cplx_in_t x,
      input cplx_in_t y,
      input logic     sub
   );
      logic signed [`FFT_NB_WIDE-1:0] xr;
      logic signed [`FFT_NB_WIDE-1:0] xi;
      logic signed [`FFT_NB_WIDE-1:0] yr;
      logic signed [`FFT_NB_WIDE-1:0] yi;
      cplx_wide_t                     r;
      xr = $signed(x.re);
      xi = $signed(x.im);
      yr = $signed(y.re);
      yi = $signed(y.im);
      if (sub) begin
         r.re = xr - yr;
         r.im = xi - yi;
      end else begin
         r.re = xr + yr;
         r.im = xi + yi;
      end
      return r;
   endfunction

   assign dd = down_dly[DELAY-1];
   assign a  = up_dly[DELAY-1];

   //////////////////////////////////////////////////
   // Commutator
   //////////////////////////////////////////////////

   always_comb begin
      if (switch) begin
         upper = dd;
         b     = lane_in.up;
      end else begin
         upper = lane_in.up;
         b     = dd;
      end
   end

   //////////////////////////////////////////////////
   // Delay lines and butterfly register
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < DELAY; i++) begin
            down_dly[i] <= '0;
            up_dly[i]   <= '0;
         end
         lane_out <= '0;
      end else begin
         down_dly[0] <= lane_in.down;
         up_dly[0]   <= upper;
         for (int i = 1; i < DELAY; i++) begin
            down_dly[i] <= down_dly[i-1];
            up_dly[i]   <= up_dly[i-1];
         end
         lane_out.up   <= bf_combine(a, b, 1'b0);
         lane_out.down <= bf_combine(a, b, 1'b1);
      end
   end

endmodule

// File: src/fix_saturate.sv
`timescale 1ns/1ps

`include "fft_tail_cfg.svh"

module fix_saturate
   import fft_tail_pkg::*;
#(
   parameter int SHIFT = `FFT_SHIFT
) (
   input  cplx_wide_t sat_in,
   output cplx_out_t  sat_out
);

   localparam int NW = `FFT_NB_WIDE;
   localparam int NO = `FFT_NB_OUT;

   // Extreme Q6.4 codes
   localparam logic [NO-1:0] SAT_HI = {1'b0, {(NO-1){1'b1}}};
   localparam logic [NO-1:0] SAT_LO = {1'b1, {(NO-1){1'b0}}};

   function automatic logic [NO-1:0] sat_part(input logic signed [NW-1:0] x);
      logic signed [NW-1:0] fl;
      fl = x >>> SHIFT;
      // Bits above the output sign must all copy it
      if (fl[NW-1:NO-1] == '0 || fl[NW-1:NO-1] == '1) begin
         return fl[NO-1:0];
      end else if (fl[NW-1]) begin
         return SAT_LO;
      end else begin
         return SAT_HI;
      end
   endfunction

   assign sat_out.re = sat_part(sat_in.re);
   assign sat_out.im = sat_part(sat_in.im);

endmodule

// File: src/fft_tail_top.sv
`timescale 1ns/1ps

`include "fft_tail_cfg.svh"

module fft_tail_top
   import fft_tail_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  lane_in_t  lane0_in,
   input  lane_in_t  lane1_in,
   output lane_out_t lane0_out,
   output lane_out_t lane1_out,
   output logic      out_valid
);

   logic       switch;
   lane_wide_t bf0_out;
   lane_wide_t bf1_out;
   cplx_out_t  s0_up;
   cplx_out_t  s0_down;
   cplx_out_t  s1_up;
   cplx_out_t  s1_down;

   //////////////////////////////////////////////////
   // Switch control
   //////////////////////////////////////////////////

   stage_sequencer seq0 (
      .clk       (clk),
      .rst_n     (rst_n),
      .switch    (switch),
      .out_valid (out_valid)
   );

   //////////////////////////////////////////////////
   // Butterfly lanes, one switch for both
   //////////////////////////////////////////////////

   mdc_butterfly bf_lane0 (
      .clk      (clk),
      .rst_n    (rst_n),
      .switch   (switch),
      .lane_in  (lane0_in),
      .lane_out (bf0_out)
   );

   mdc_butterfly bf_lane1 (
      .clk      (clk),
      .rst_n    (rst_n),
      .switch   (switch),
      .lane_in  (lane1_in),
      .lane_out (bf1_out)
   );

   //////////////////////////////////////////////////
   // Q7.15 to Q6.4
   //////////////////////////////////////////////////

   fix_saturate sat0_up (
      .sat_in  (bf0_out.up),
      .sat_out (s0_up)
   );

   fix_saturate sat0_down (
      .sat_in  (bf0_out.down),
      .sat_out (s0_down)
   );

   fix_saturate sat1_up (
      .sat_in  (bf1_out.up),
      .sat_out (s1_up)
   );

   fix_saturate sat1_down (
      .sat_in  (bf1_out.down),
      .sat_out (s1_down)
   );

   assign lane0_out = '{up: s0_up, down: s0_down};
   assign lane1_out = '{up: s1_up, down: s1_down};

endmodule

// File: bench/fft_tail_checker.sv
`timescale 1ns/1ps

`include "fft_tail_cfg.svh"

module fft_tail_checker
   import fft_tail_pkg::*;
#(
   parameter int DELAY = `FFT_DELAY,
   parameter int PH_W  = $clog2(`FFT_DELAY) + 2
) (
   input logic            clk,
   input logic            rst_n,
   input seq_state_t      state,
   input logic [PH_W-1:0] phase,
   input logic            switch,
   input logic            out_valid
);

   // Switch held idle until the pipeline has filled
   switch_idle_in_fill: assert property (
      @(posedge clk) disable iff (!rst_n) (state == SEQ_FILL) |-> !switch
   ) else $error("switch high while the sequencer is filling");

   valid_only_in_run: assert property (
      @(posedge clk) disable iff (!rst_n) out_valid |-> (state == SEQ_RUN)
   ) else $error("out_valid high outside the run state");

   // Toggles land on half-period boundaries
   switch_on_boundary: assert property (
      @(posedge clk) disable iff (!rst_n) $changed(switch) |-> ((phase % DELAY) == 0)
   ) else $error("switch changed away from a half-period boundary");

endmodule

bind stage_sequencer fft_tail_checker chk0 (
   .clk       (clk),
   .rst_n     (rst_n),
   .state     (state),
   .phase     (phase),
   .switch    (switch),
   .out_valid (out_valid)
);

// File: bench/tb_fft_tail.sv
`timescale 1ns/1ps

`include "fft_tail_cfg.svh"

module tb_fft_tail
   import fft_tail_pkg::*;
();

   localparam int DELAY      = `FFT_DELAY;
   localparam int VALID_CYC  = `FFT_FILL + 2 * `FFT_DELAY + 1;
   localparam int SAT_MAX    = (1 << (`FFT_NB_OUT - 1)) - 1;
   localparam int SAT_MIN    = -(1 << (`FFT_NB_OUT - 1));
   // Small parts keep every sum inside the Q6.4 range
   localparam int SMALL_W    = 18;
   localparam int MODE_ZERO  = 0;
   localparam int MODE_SMALL = 1;
   localparam int MODE_FULL  = 2;
   localparam int MODE_SOLO  = 3;

   logic        clk;
   logic        rst_n;
   lane_in_t    lane0_in;
   lane_in_t    lane1_in;
   lane_out_t   lane0_out;
   lane_out_t   lane1_out;
   logic        out_valid;
   logic [15:0] lfsr;
   int          cyc;
   int          errors;
   int          clamps;
   logic        exp_valid;
   string       test_name;

   // Cycle model with one entry per lane
   cplx_in_t m_down [2][DELAY];
   cplx_in_t m_up [2][DELAY];
   // Up re, up im, down re, down im
   int       m_wide [2][4];

   fft_tail_top dut0 (
      .clk       (clk),
      .rst_n     (rst_n),
      .lane0_in  (lane0_in),
      .lane1_in  (lane1_in),
      .lane0_out (lane0_out),
      .lane1_out (lane1_out),
      .out_valid (out_valid)
   );

   always #50 clk = ~clk;

   //////////////////////////////////////////////////
   // Stimulus source
   //////////////////////////////////////////////////

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   function automatic logic [`FFT_NB_IN-1:0] rand_part(input int mode);
      logic [31:0] r;
      if (mode == MODE_ZERO) begin
         return '0;
      end
      if (mode == MODE_FULL) begin
         // Half the parts sit on the extreme codes
         r = rand_bits(2);
         if (r == 0) begin
            return {1'b0, {(`FFT_NB_IN-1){1'b1}}};
         end
         if (r == 1) begin
            return {1'b1, {(`FFT_NB_IN-1){1'b0}}};
         end
         r = rand_bits(`FFT_NB_IN);
         return r[`FFT_NB_IN-1:0];
      end
      r = rand_bits(SMALL_W);
      return {{(`FFT_NB_IN-SMALL_W){r[SMALL_W-1]}}, r[SMALL_W-1:0]};
   endfunction

   function automatic lane_in_t make_lane(input int mode);
      lane_in_t v;
      v.up.re   = rand_part(mode);
      v.up.im   = rand_part(mode);
      v.down.re = rand_part(mode);
      v.down.im = rand_part(mode);
      return v;
   endfunction

   //////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////

   // Floor to Q6.4 and clamp
   function automatic int saturate(input int v);
      int f;
      f = v >>> `FFT_SHIFT;
      if (f > SAT_MAX) begin
         return SAT_MAX;
      end
      if (f < SAT_MIN) begin
         return SAT_MIN;
      end
      return f;
   endfunction

   function automatic integer out_part(input lane_out_t v, input int k);
      case (k)
         0: return $signed(v.up.re);
         1: return $signed(v.up.im);
         2: return $signed(v.down.re);
         default: return $signed(v.down.im);
      endcase
   endfunction

   task automatic model_edge();
      logic     sw;
      lane_in_t lin;
      cplx_in_t dd;
      cplx_in_t a;
      cplx_in_t upper;
      cplx_in_t b;
      // Switch level before this edge
      sw = (cyc >= `FFT_FILL) && ((((cyc - `FFT_FILL) / DELAY) % 2) == 1);
      for (int l = 0; l < 2; l++) begin
         lin   = (l == 0) ? lane0_in : lane1_in;
         dd    = m_down[l][DELAY-1];
         a     = m_up[l][DELAY-1];
         upper = sw ? dd : lin.up;
         b     = sw ? lin.up : dd;
         m_wide[l][0] = $signed(a.re) + $signed(b.re);
         m_wide[l][1] = $signed(a.im) + $signed(b.im);
         m_wide[l][2] = $signed(a.re) - $signed(b.re);
         m_wide[l][3] = $signed(a.im) - $signed(b.im);
         for (int i = DELAY - 1; i > 0; i--) begin
            m_down[l][i] = m_down[l][i-1];
            m_up[l][i]   = m_up[l][i-1];
         end
         m_down[l][0] = lin.down;
         m_up[l][0]   = upper;
      end
      cyc++;
      exp_valid = (cyc >= VALID_CYC);
   endtask

   //////////////////////////////////////////////////
   // Cycle stepping and checks
   //////////////////////////////////////////////////

   task automatic compare_outputs();
      lane_out_t got;
      int        exp_v;
      integer    act_v;
      if (out_valid !== exp_valid) begin
         errors++;
         $display("ERROR %s cycle %0d out_valid: expected %0d actual %0d",
                  test_name, cyc, exp_valid, out_valid);
      end
      for (int l = 0; l < 2; l++) begin
         got = (l == 0) ? lane0_out : lane1_out;
         for (int k = 0; k < 4; k++) begin
            exp_v = saturate(m_wide[l][k]);
            act_v = out_part(got, k);
            if ((m_wide[l][k] >>> `FFT_SHIFT) != exp_v) begin
               clamps++;
            end
            if (act_v !== exp_v) begin
               errors++;
               $display("ERROR %s cycle %0d lane%0d part%0d: expected %0d actual %0d",
                        test_name, cyc, l, k, exp_v, act_v);
            end
         end
      end
   endtask

   task automatic drive_inputs(input int mode);
      if (mode == MODE_SOLO) begin
         lane0_in = make_lane(MODE_SMALL);
         lane1_in = '0;
      end else begin
         lane0_in = make_lane(mode);
         lane1_in = make_lane(mode);
      end
   endtask

   // Check and drive 1 ns after each rising edge
   task automatic step_cycle(input int mode);
      @(posedge clk);
      model_edge();
      #1;
      compare_outputs();
      drive_inputs(mode);
   endtask

   task automatic run_cycles(input int n, input int mode);
      for (int i = 0; i < n; i++) begin
         step_cycle(mode);
      end
   endtask

   task automatic wait_valid(input int limit);
      int n;
      n = 0;
      while (out_valid !== 1'b1 && n < limit) begin
         step_cycle(MODE_ZERO);
         n++;
      end
      if (out_valid !== 1'b1) begin
         errors++;
         $display("out_valid did not rise within %0d cycles after reset", limit);
      end else if (cyc != VALID_CYC) begin
         errors++;
         $display("ERROR %s rise cycle: expected %0d actual %0d", test_name, VALID_CYC, cyc);
      end
   endtask

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////

   initial begin
      clk       = 1'b0;
      rst_n     = 1'b0;
      lane0_in  = '0;
      lane1_in  = '0;
      lfsr      = 16'd82;
      cyc       = 0;
      errors    = 0;
      clamps    = 0;
      exp_valid = 1'b0;
      m_down    = '{default: '0};
      m_up      = '{default: '0};
      m_wide    = '{default: 0};
      test_name = "reset_fill";
      repeat (5) @(posedge clk);
      #1;
      rst_n = 1'b1;
      wait_valid(VALID_CYC + 20);

      test_name = "butterfly_data";
      run_cycles(200, MODE_SMALL);

      test_name = "saturation";
      clamps = 0;
      run_cycles(150, MODE_FULL);
      if (clamps == 0) begin
         errors++;
         $display("Full-scale inputs never pushed a result out of the Q6.4 range");
      end

      test_name = "lane_independence";
      for (int i = 0; i < 120; i++) begin
         step_cycle(MODE_SOLO);
         // Lane 1 has drained once both delay lines have flushed
         if (i > 2 * DELAY + 2 && lane1_out !== '0) begin
            errors++;
            $display("ERROR %s cycle %0d lane1_out: expected 0 actual %h",
                     test_name, cyc, lane1_out);
         end
      end

      $display("Checks done after %0d cycles: %0d errors, %0d clamped parts",
               cyc, errors, clamps);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: fft_tail.f
+incdir+src
src/fft_tail_pkg.sv
src/stage_sequencer.sv
src/mdc_butterfly.sv
src/fix_saturate.sv
src/fft_tail_top.sv
bench/fft_tail_checker.sv
bench/tb_fft_tail.sv

// File: Bender.yml
package:
  name: fft_tail

export_include_dirs:
  - src

sources:
  - src/fft_tail_pkg.sv
  - src/stage_sequencer.sv
  - src/mdc_butterfly.sv
  - src/fix_saturate.sv
  - src/fft_tail_top.sv
  - target: test
    files:
      - bench/fft_tail_checker.sv
      - bench/tb_fft_tail.sv
